//--- verification/fetch_patterns.txt
# kind name addr_or_word_index input_data expected_line, numbers in hex
# F fetch, W debug write, U unmapped, I icache only, C icache plus pending fetch, B back to back
F brom_line0 100 0 B0000003B0000002B0000001B0000000
F brom_line5_mid 15c 0 B0000017B0000016B0000015B0000014
F brom_line7_last 17f 0 B000001FB000001EB000001DB000001C
F pbuf_reset_line0 800 0 0
F pbuf_reset_line3 830 0 0
W dbg_word4 4 00100093 0
W dbg_word5 5 00200113 0
W dbg_word6 6 002081b3 0
W dbg_word7 7 00100073 0
F pbuf_line1 810 0 00100073002081b30020011300100093
F pbuf_line0_untouched 80c 0 0
W dbg_word12 c 0000006f 0
F pbuf_line3_next_cycle 830 0 0000000000000000000000000000006f
U unmapped_zero 0 0 0
U unmapped_below_brom f0 0 0
U unmapped_above_brom 180 0 0
U unmapped_above_pbuf 840 0 0
I icache_only_a 0 0 0
I icache_only_b 0 0 0
C collide_brom 120 0123456789abcdef0123456789abcdef B000000BB000000AB0000009B0000008
C collide_pbuf 818 ffffffffffffffffffffffffffffffff 00100073002081b30020011300100093
B b2b_brom 130 0 B000000FB000000EB000000DB000000C
F b2b_pbuf 814 0 00100073002081b30020011300100093

//--- project.f
source/sargantana_fetch_pkg.sv
source/fetch_req_if.sv
source/boot_rom.sv
source/progbuf_regs.sv
source/fetch_router.sv
source/fetch_subsystem.sv
verification/tb_fetch_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Builds the fetch subsystem testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_subsystem -f project.f -o sim_fetch
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_fetch)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Test completed successfully$"; then
    exit 0
fi
exit 1

//--- verification/tb_fetch_subsystem.sv
`timescale 1ns/1ps

module tb_fetch_subsystem;
    import sargantana_fetch_pkg::*;

    localparam int BROM_LINES    = 8;
    localparam int PROGBUF_WORDS = 16;
    localparam int IDX_W         = $clog2(PROGBUF_WORDS);

    logic             clk_i;
    logic             sargantana_rstn;
    logic             uc_fetch_req_valid_i;
    paddr_t           uc_fetch_req_addr_i;
    logic             uc_fetch_ready_o;
    logic             icache_resp_valid_i;
    fetch_line_t      icache_resp_data_i;
    logic             core_resp_valid_o;
    fetch_line_t      core_resp_data_o;
    logic             dbg_we_i;
    logic [IDX_W-1:0] dbg_word_idx_i;
    dbg_word_t        dbg_wdata_i;

    // One entry per pattern line
    string       kinds[$];
    string       names[$];
    paddr_t      addrs[$];
    fetch_line_t datas[$];
    fetch_line_t exps[$];

    int   pass_count  = 0;
    int   fail_count  = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;  // Armed once the patterns are known
    logic test_ok     = 1'b1;

    fetch_subsystem #(
        .BROM_LINES    (BROM_LINES),
        .PROGBUF_WORDS (PROGBUF_WORDS)
    ) DUT (.*);

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic clear_inputs();
        uc_fetch_req_valid_i = 1'b0;
        uc_fetch_req_addr_i  = '0;
        icache_resp_valid_i  = 1'b0;
        icache_resp_data_i   = '0;
        dbg_we_i             = 1'b0;
        dbg_word_idx_i       = '0;
        dbg_wdata_i          = '0;
    endtask

    task automatic check_line(input string name, input fetch_line_t exp, input fetch_line_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h actual %h", name, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_valid(input string name, input string sig, input logic exp,
                               input logic act);
        if (act !== exp) begin
            if (exp) begin
                $display("%s: %s did not go high when it should have", name, sig);
            end else begin
                $display("%s: %s went high when it should have stayed low", name, sig);
            end
            test_ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name);
        if (test_ok) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
        test_ok = 1'b1;
    endtask

    task automatic read_patterns();
        int          fd;
        int          n;
        string       line;
        string       kind;
        string       name;
        paddr_t      addr;
        fetch_line_t data;
        fetch_line_t expected;
        fd = $fopen("verification/fetch_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/fetch_patterns.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %h", kind, name, addr, data, expected);
            if (n == 5) begin
                kinds.push_back(kind);
                names.push_back(name);
                addrs.push_back(addr);
                datas.push_back(data);
                exps.push_back(expected);
            end
        end
        $fclose(fd);
    endtask

    // New request on the falling edge, everything else idle
    task automatic drive_fetch(input paddr_t addr);
        @(negedge clk_i);
        clear_inputs();
        uc_fetch_req_valid_i = 1'b1;
        uc_fetch_req_addr_i  = addr;
    endtask

    task automatic expect_line(input int i);
        check_valid(names[i], "core_resp_valid_o", 1'b1, core_resp_valid_o);
        check_line(names[i], exps[i], core_resp_data_o);
    endtask

    task automatic mapped_fetch(input int i);
        drive_fetch(addrs[i]);
        #2;
        check_valid(names[i], "uc_fetch_ready_o", 1'b1, uc_fetch_ready_o);
        check_valid(names[i], "core_resp_valid_o", 1'b0, core_resp_valid_o); // Too early
        @(negedge clk_i);
        clear_inputs();
        #2;
        expect_line(i);
        report_test(names[i]);
    endtask

    task automatic unmapped_fetch(input int i);
        drive_fetch(addrs[i]);
        #2;
        check_valid(names[i], "uc_fetch_ready_o", 1'b0, uc_fetch_ready_o);
        @(negedge clk_i);
        clear_inputs();
        #2;
        check_valid(names[i], "core_resp_valid_o", 1'b0, core_resp_valid_o);
        report_test(names[i]);
    endtask

    task automatic icache_passthrough(input int i);
        fetch_line_t ic_data;
        @(negedge clk_i);
        clear_inputs();
        ic_data             = {$urandom, $urandom, $urandom, $urandom};
        icache_resp_valid_i = 1'b1;
        icache_resp_data_i  = ic_data;
        #2;
        check_valid(names[i], "core_resp_valid_o", 1'b1, core_resp_valid_o);
        check_line(names[i], ic_data, core_resp_data_o); // Passed straight through
        report_test(names[i]);
    endtask

    task automatic collision_fetch(input int i);
        drive_fetch(addrs[i]);
        #2;
        check_valid(names[i], "uc_fetch_ready_o", 1'b1, uc_fetch_ready_o);
        @(negedge clk_i);
        clear_inputs();
        icache_resp_valid_i = 1'b1;
        icache_resp_data_i  = datas[i];
        #2;
        expect_line(i);
        @(negedge clk_i);
        clear_inputs();
        #2;
        check_valid(names[i], "core_resp_valid_o", 1'b0, core_resp_valid_o); // Single pulse
        report_test(names[i]);
    endtask

    // Second request goes out while the first answer is on the bus
    task automatic back_to_back_fetch(input int i);
        drive_fetch(addrs[i]);
        #2;
        check_valid(names[i], "uc_fetch_ready_o", 1'b1, uc_fetch_ready_o);
        drive_fetch(addrs[i+1]);
        #2;
        expect_line(i);
        report_test(names[i]);
        check_valid(names[i+1], "uc_fetch_ready_o", 1'b1, uc_fetch_ready_o);
        @(negedge clk_i);
        clear_inputs();
        #2;
        expect_line(i + 1);
        report_test(names[i+1]);
    endtask

    initial begin
        int idx;
        void'($urandom(32'h80e0_dd3a));
        clk_i           = 1'b0;
        sargantana_rstn = 1'b0;
        clear_inputs();
        uc_fetch_req_valid_i = 1'b1; // Held through reset, must leave no response behind
        uc_fetch_req_addr_i  = BROM_BASE;
        read_patterns();
        if (kinds.size() == 0) begin
            $display("No patterns were read, nothing to run");
            fail_count++;
        end
        cycle_limit = 4 * kinds.size() + 20;
        repeat (3) @(negedge clk_i);
        clear_inputs();
        sargantana_rstn = 1'b1;
        #2;
        check_valid("after_reset", "core_resp_valid_o", 1'b0, core_resp_valid_o);
        report_test("after_reset");

        idx = 0;
        while (idx < kinds.size()) begin
            if (kinds[idx] == "W") begin
                @(negedge clk_i);
                clear_inputs();
                dbg_we_i       = 1'b1;
                dbg_word_idx_i = addrs[idx][IDX_W-1:0];
                dbg_wdata_i    = datas[idx][31:0];
            end else if (kinds[idx] == "F") begin
                mapped_fetch(idx);
            end else if (kinds[idx] == "U") begin
                unmapped_fetch(idx);
            end else if (kinds[idx] == "I") begin
                icache_passthrough(idx);
            end else if (kinds[idx] == "C") begin
                collision_fetch(idx);
            end else if (kinds[idx] == "B" && idx + 1 < kinds.size() && kinds[idx+1] == "F") begin
                back_to_back_fetch(idx);
                idx++;
            end else begin
                $display("Pattern %s has kind %s, which cannot be run here",
                         names[idx], kinds[idx]);
                fail_count++;
            end
            idx++;
        end

        @(negedge clk_i);
        clear_inputs();
        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- source/fetch_subsystem.sv
`timescale 1ns/1ps

module fetch_subsystem #(
    parameter int BROM_LINES    = 8,
    parameter int PROGBUF_WORDS = 16
) (
    input  logic                              clk_i,
    input  logic                              sargantana_rstn,

    // Uncacheable fetch from the core
    input  logic                              uc_fetch_req_valid_i,
    input  sargantana_fetch_pkg::paddr_t      uc_fetch_req_addr_i,
    output logic                              uc_fetch_ready_o,

    // Instruction cache refill
    input  logic                              icache_resp_valid_i,
    input  sargantana_fetch_pkg::fetch_line_t icache_resp_data_i,

    // Merged response toward the core
    output logic                              core_resp_valid_o,
    output sargantana_fetch_pkg::fetch_line_t core_resp_data_o,

    // Debug writes into the program buffer
    input  logic                              dbg_we_i,
    input  logic [$clog2(PROGBUF_WORDS)-1:0]  dbg_word_idx_i,
    input  sargantana_fetch_pkg::dbg_word_t   dbg_wdata_i
);

    fetch_req_if brom_if (.clk_i(clk_i), .sargantana_rstn(sargantana_rstn));
    fetch_req_if pbuf_if (.clk_i(clk_i), .sargantana_rstn(sargantana_rstn));

    fetch_router #(
        .BROM_LINES    (BROM_LINES),
        .PROGBUF_WORDS (PROGBUF_WORDS)
    ) router_inst (
        .uc_fetch_req_valid_i (uc_fetch_req_valid_i),
        .uc_fetch_req_addr_i  (uc_fetch_req_addr_i),
        .uc_fetch_ready_o     (uc_fetch_ready_o),
        .icache_resp_valid_i  (icache_resp_valid_i),
        .icache_resp_data_i   (icache_resp_data_i),
        .core_resp_valid_o    (core_resp_valid_o),
        .core_resp_data_o     (core_resp_data_o),
        .brom_if              (brom_if.router),
        .pbuf_if              (pbuf_if.router)
    );

    boot_rom #(
        .BROM_LINES (BROM_LINES)
    ) brom (
        .clk_i           (clk_i),
        .sargantana_rstn (sargantana_rstn),
        .fetch           (brom_if.target)
    );

    progbuf_regs #(
        .PROGBUF_WORDS (PROGBUF_WORDS)
    ) prog_buf (
        .clk_i           (clk_i),
        .sargantana_rstn (sargantana_rstn),
        .dbg_we_i        (dbg_we_i),
        .dbg_word_idx_i  (dbg_word_idx_i),
        .dbg_wdata_i     (dbg_wdata_i),
        .fetch           (pbuf_if.target)
    );

endmodule

//--- source/fetch_router.sv
`timescale 1ns/1ps

module fetch_router #(
    parameter int BROM_LINES    = 8,
    parameter int PROGBUF_WORDS = 16
) (
    input  logic                              uc_fetch_req_valid_i,
    input  sargantana_fetch_pkg::paddr_t      uc_fetch_req_addr_i,
    output logic                              uc_fetch_ready_o,

    input  logic                              icache_resp_valid_i,
    input  sargantana_fetch_pkg::fetch_line_t icache_resp_data_i,

    output logic                              core_resp_valid_o,
    output sargantana_fetch_pkg::fetch_line_t core_resp_data_o,

    fetch_req_if.router                       brom_if,
    fetch_req_if.router                       pbuf_if
);
    import sargantana_fetch_pkg::*;

    // Last byte actually backed by ROM lines
    localparam paddr_t BROM_LINES_END = BROM_BASE + paddr_t'(BROM_LINES * LINE_BYTES - 1);
    localparam paddr_t BROM_TOP       = (BROM_LINES_END < BROM_END) ? BROM_LINES_END : BROM_END;
    localparam paddr_t PROGBUF_TOP    =
        PROGBUF_BASE + paddr_t'(PROGBUF_WORDS * (DBG_WORD_WIDTH / 8) - 1);

    fetch_target_e fetch_tgt;
    paddr_t        brom_off;
    paddr_t        pbuf_off;
    logic          uc_resp_valid;
    fetch_line_t   uc_resp_data;

    always_comb begin
        if (uc_fetch_req_addr_i >= BROM_BASE && uc_fetch_req_addr_i <= BROM_TOP) begin
            fetch_tgt = TARGET_BROM;
        end else if (uc_fetch_req_addr_i >= PROGBUF_BASE && uc_fetch_req_addr_i <= PROGBUF_TOP) begin
            fetch_tgt = TARGET_PROGBUF;
        end else begin
            fetch_tgt = TARGET_NONE;
        end
    end

    assign brom_off = uc_fetch_req_addr_i - BROM_BASE;
    assign pbuf_off = uc_fetch_req_addr_i - PROGBUF_BASE;

    assign brom_if.req_valid = uc_fetch_req_valid_i && (fetch_tgt == TARGET_BROM);
    assign brom_if.req_line  = brom_off[LINE_OFFSET_BITS +: LINE_IDX_WIDTH];
    assign pbuf_if.req_valid = uc_fetch_req_valid_i && (fetch_tgt == TARGET_PROGBUF);
    assign pbuf_if.req_line  = pbuf_off[LINE_OFFSET_BITS +: LINE_IDX_WIDTH];

    always_comb begin
        case (fetch_tgt)
            TARGET_BROM:    uc_fetch_ready_o = brom_if.ready;
            TARGET_PROGBUF: uc_fetch_ready_o = pbuf_if.ready;
            default:        uc_fetch_ready_o = 1'b0; // Unmapped
        endcase
    end

    // Responses come a cycle after the request, so pick by valid and not by the current decode
    assign uc_resp_valid = brom_if.resp_valid | pbuf_if.resp_valid;
    assign uc_resp_data  = brom_if.resp_valid ? brom_if.resp_data : pbuf_if.resp_data;

    // Uncacheable line wins over an icache refill in the same cycle
    assign core_resp_valid_o = uc_resp_valid | icache_resp_valid_i;
    assign core_resp_data_o  = uc_resp_valid ? uc_resp_data : icache_resp_data_i;

    a_single_target_resp: assert property (@(posedge brom_if.clk_i)
        disable iff (~brom_if.sargantana_rstn)
        !(brom_if.resp_valid && pbuf_if.resp_valid))
        else $error("fetch_router: both targets answered in one cycle");

    a_no_req_unmapped: assert property (@(posedge brom_if.clk_i)
        disable iff (~brom_if.sargantana_rstn)
        (fetch_tgt == TARGET_NONE) |-> !(brom_if.req_valid || pbuf_if.req_valid))
        else $error("fetch_router: request raised for unmapped address");

endmodule

//--- source/progbuf_regs.sv
`timescale 1ns/1ps

module progbuf_regs #(
    parameter int PROGBUF_WORDS = 16
) (
    input logic                             clk_i,
    input logic                             sargantana_rstn,
    input logic                             dbg_we_i,
    input logic [$clog2(PROGBUF_WORDS)-1:0] dbg_word_idx_i,
    input sargantana_fetch_pkg::dbg_word_t  dbg_wdata_i,
    fetch_req_if.target                     fetch
);
    import sargantana_fetch_pkg::*;

    localparam int IDX_W = $clog2(PROGBUF_WORDS);

    dbg_word_t                        words_q [PROGBUF_WORDS];
    logic [IDX_W-1:0]                 rd_base;  // First word of the addressed line
    dbg_word_t [WORDS_PER_LINE-1:0]   line_d;
    logic                             resp_valid_q;
    fetch_line_t                      resp_data_q;

    // Debug side writes one word at a time
    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            for (int i = 0; i < PROGBUF_WORDS; i++) begin
                words_q[i] <= '0;
            end
        end else if (dbg_we_i) begin
            words_q[dbg_word_idx_i] <= dbg_wdata_i;
        end
    end

    assign rd_base = IDX_W'(int'(fetch.req_line) * WORDS_PER_LINE);

    // Gather four consecutive words, lowest word in the low bits
    always_comb begin
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            line_d[k] = words_q[rd_base + IDX_W'(k)];
        end
    end

    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= fetch.req_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch.req_valid) begin
            resp_data_q <= line_d;
        end
    end

    assign fetch.ready      = 1'b1;
    assign fetch.resp_valid = resp_valid_q;
    assign fetch.resp_data  = resp_data_q;

    // Index port is wider than the buffer when the word count is not a power of two
    a_dbg_idx_in_range: assert property (@(posedge clk_i) disable iff (~sargantana_rstn)
        dbg_we_i |-> int'(dbg_word_idx_i) < PROGBUF_WORDS)
        else $error("progbuf_regs: debug write to word %0d", dbg_word_idx_i);

endmodule

//--- source/boot_rom.sv
`timescale 1ns/1ps

module boot_rom #(
    parameter int BROM_LINES = 8
) (
    input logic          clk_i,
    input logic          sargantana_rstn,
    fetch_req_if.target  fetch
);
    import sargantana_fetch_pkg::*;

    fetch_line_t rom_line;
    logic        resp_valid_q;
    fetch_line_t resp_data_q;

    // Word k of line i holds B000_0000 + 4*i + k
    always_comb begin
        rom_line = '0;
        if (int'(fetch.req_line) < BROM_LINES) begin
            case (fetch.req_line)
                8'd0:    rom_line = 128'hB000_0003_B000_0002_B000_0001_B000_0000;
                8'd1:    rom_line = 128'hB000_0007_B000_0006_B000_0005_B000_0004;
                8'd2:    rom_line = 128'hB000_000B_B000_000A_B000_0009_B000_0008;
                8'd3:    rom_line = 128'hB000_000F_B000_000E_B000_000D_B000_000C;
                8'd4:    rom_line = 128'hB000_0013_B000_0012_B000_0011_B000_0010;
                8'd5:    rom_line = 128'hB000_0017_B000_0016_B000_0015_B000_0014;
                8'd6:    rom_line = 128'hB000_001B_B000_001A_B000_0019_B000_0018;
                8'd7:    rom_line = 128'hB000_001F_B000_001E_B000_001D_B000_001C;
                default: rom_line = '0; // Past the populated table
            endcase
        end
    end

    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= fetch.req_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch.req_valid) begin
            resp_data_q <= rom_line;
        end
    end

    assign fetch.ready      = 1'b1; // Never stalls
    assign fetch.resp_valid = resp_valid_q;
    assign fetch.resp_data  = resp_data_q;

    // Router must not hand over an index past the ROM contents
    a_brom_line_in_range: assert property (@(posedge clk_i) disable iff (~sargantana_rstn)
        fetch.req_valid |-> int'(fetch.req_line) < BROM_LINES)
        else $error("boot_rom: line index %0d out of range", fetch.req_line);

endmodule

//--- source/fetch_req_if.sv
`timescale 1ns/1ps

interface fetch_req_if (
    input logic clk_i,
    input logic sargantana_rstn
);
    import sargantana_fetch_pkg::*;

    logic        req_valid;  // Single cycle request strobe
    line_idx_t   req_line;   // Line index relative to the target base
    logic        ready;      // Level, target always accepts
    logic        resp_valid;
    fetch_line_t resp_data;

    // Clock and reset are only seen by the router for its checks
    modport router (
        input  clk_i, sargantana_rstn,
        output req_valid, req_line,
        input  ready, resp_valid, resp_data
    );

    modport target (
        input  req_valid, req_line,
        output ready, resp_valid, resp_data
    );

endinterface

//--- source/sargantana_fetch_pkg.sv
package sargantana_fetch_pkg;

    // Bus and line geometry
    localparam int PADDR_WIDTH      = 40;
    localparam int FETCH_LINE_WIDTH = 128;
    localparam int DBG_WORD_WIDTH   = 32;
    localparam int WORDS_PER_LINE   = FETCH_LINE_WIDTH / DBG_WORD_WIDTH;
    localparam int LINE_BYTES       = FETCH_LINE_WIDTH / 8;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES); // Byte offset inside a line

    // Line index inside a target, wide enough for any region here
    localparam int LINE_IDX_WIDTH = 8;

    typedef logic [PADDR_WIDTH-1:0]      paddr_t;
    typedef logic [FETCH_LINE_WIDTH-1:0] fetch_line_t;
    typedef logic [DBG_WORD_WIDTH-1:0]   dbg_word_t;
    typedef logic [LINE_IDX_WIDTH-1:0]   line_idx_t;

    // Boot ROM region, bounds inclusive
    localparam paddr_t BROM_BASE = 40'h00_0000_0100;
    localparam paddr_t BROM_END  = 40'h00_0000_017F;

    // Program buffer region, end follows from the word count
    localparam paddr_t PROGBUF_BASE = 40'h00_0000_0800;

    // Decoded target of an uncacheable fetch
    typedef enum logic [1:0] {
        TARGET_NONE    = 2'd0,
        TARGET_BROM    = 2'd1,
        TARGET_PROGBUF = 2'd2
    } fetch_target_e;

endpackage
